// ==== rtl/fetch_pkg.sv ====
// fetch front end shared types: widths, opcodes, length rule, slot and group structs
`default_nettype none

package fetch_pkg;

	// ========================================
	// widths and constants
	// ========================================
	localparam int ADDR_W = 16;
	localparam int BYTE_W = 8;
	localparam int WINDOW_BYTES = 8;
	localparam int INSN_BYTES = 3;

	// first fetch address after reset
	localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'h0200;

	// opcodes the front end cares about
	localparam logic [BYTE_W-1:0] OP_JMP = 8'h4C;
	localparam logic [BYTE_W-1:0] OP_JSR = 8'h20;
	localparam logic [BYTE_W-1:0] OP_RTS = 8'h60;
	localparam logic [BYTE_W-1:0] OP_BRK = 8'h00;

	// relative branches share this low-five-bit pattern
	localparam logic [4:0] BRANCH_PATTERN = 5'b10000;

	typedef logic [ADDR_W-1:0] addr_t;
	// byte 0 sits in bits 7:0
	typedef logic [WINDOW_BYTES*BYTE_W-1:0] window_t;
	// 1 to 3, zero never produced
	typedef logic [1:0] insn_len_t;
	// opcode, operand low, operand high
	typedef logic [INSN_BYTES*BYTE_W-1:0] insn_t;

	typedef enum logic [2:0] {
		xfer_none   = 3'd0,
		xfer_branch = 3'd1,
		xfer_jump   = 3'd2,
		xfer_call   = 3'd3,
		xfer_return = 3'd4
	} xfer_class_e;

	// per-slot predecode result, 22 bits
	typedef struct packed {
		insn_len_t   len;
		xfer_class_e xclass;
		logic        taken;
		addr_t       target;
	} slot_decode_t;

	// what decode sees, 82 bits
	typedef struct packed {
		logic  valid0;
		logic  valid1;
		addr_t pc0;
		addr_t pc1;
		insn_t insn0;
		insn_t insn1;
	} fetch_group_t;

	typedef enum logic [1:0] {
		bus_idle = 2'd0,
		bus_read = 2'd1,
		bus_hold = 2'd2
	} bus_state_e;

	// ========================================
	// opcode helpers
	// ========================================
	function automatic logic is_rel_branch(input logic [BYTE_W-1:0] op);
		return op[4:0] == BRANCH_PATTERN;
	endfunction

	// instruction length table, first match wins
	function automatic insn_len_t len_of(input logic [BYTE_W-1:0] op);
		insn_len_t len;
		len = 2'd2;
		casez (op)
			OP_JMP, OP_JSR: len = 2'd3;
			OP_RTS, OP_BRK: len = 2'd1;
			// branches are opcode plus offset
			8'b???1_0000: len = 2'd2;
			// A9 family, overrides the x9 column below
			8'b???0_1001: len = 2'd1;
			8'b????_1001, 8'b????_1100, 8'b????_1101, 8'b????_1110: len = 2'd3;
			8'b????_1000, 8'b????_1010: len = 2'd1;
			default: len = 2'd2;
		endcase
		return len;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/insn_predecode.sv ====
// slot predecoder: instruction length, transfer class, static prediction and target
`default_nettype none

module insn_predecode (
	input  fetch_pkg::addr_t        slot_pc,
	input  fetch_pkg::insn_t        bytes,
	input  fetch_pkg::addr_t        ra,
	output fetch_pkg::slot_decode_t dec
);

	logic [7:0] op;
	fetch_pkg::insn_len_t len;
	// absolute operand word for jmp and jsr
	fetch_pkg::addr_t operand;
	// branch offset, sign extended to an address
	fetch_pkg::addr_t rel_off;
	// address of the following instruction
	fetch_pkg::addr_t fall_pc;

	assign op = bytes[7:0];
	assign len = fetch_pkg::len_of(op);
	assign operand = bytes[23:8];
	assign rel_off = {{8{bytes[15]}}, bytes[15:8]};
	assign fall_pc = slot_pc + fetch_pkg::addr_t'(len);

	// ========================================
	// class, prediction and target
	// ========================================
	always_comb begin
		dec.len = len;
		dec.xclass = fetch_pkg::xfer_none;
		dec.taken = 1'b0;
		dec.target = fall_pc;
		if (op == fetch_pkg::OP_JMP) begin
			dec.xclass = fetch_pkg::xfer_jump;
			dec.taken = 1'b1;
			dec.target = operand;
		end else if (op == fetch_pkg::OP_JSR) begin
			dec.xclass = fetch_pkg::xfer_call;
			dec.taken = 1'b1;
			dec.target = operand;
		end else if (op == fetch_pkg::OP_RTS) begin
			// return address comes from the core's stack tracking
			dec.xclass = fetch_pkg::xfer_return;
			dec.taken = 1'b1;
			dec.target = ra;
		end else if (fetch_pkg::is_rel_branch(op)) begin
			// backward taken, forward not taken
			dec.xclass = fetch_pkg::xfer_branch;
			dec.taken = bytes[15];
			dec.target = fall_pc + rel_off;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fetch_bus_master.sv ====
// Wishbone classic read master, one 8-byte window per fetch request
`default_nettype none

module fetch_bus_master (
	input  logic               clk,
	input  logic               rst,
	input  logic               fetch_req,
	input  fetch_pkg::addr_t   fetch_adr,
	input  logic               flush,
	input  fetch_pkg::window_t wb_dat_i,
	input  logic               wb_ack,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output fetch_pkg::addr_t   wb_adr,
	output fetch_pkg::window_t window,
	output logic               window_valid
);

	fetch_pkg::bus_state_e state;
	// address held for the whole cycle
	fetch_pkg::addr_t adr_q;

	// ========================================
	// bus state machine
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fetch_pkg::bus_idle;
		end else begin
			case (state)
				fetch_pkg::bus_idle: begin
					// a flush in the same cycle means the address is stale
					if (fetch_req && !flush)
						state <= fetch_pkg::bus_read;
				end
				fetch_pkg::bus_read: begin
					if (wb_ack)
						state <= fetch_pkg::bus_idle;
					else if (flush)
						state <= fetch_pkg::bus_hold;
				end
				fetch_pkg::bus_hold: begin
					// wait out the abandoned cycle, data is dropped
					if (wb_ack)
						state <= fetch_pkg::bus_idle;
				end
				default: state <= fetch_pkg::bus_idle;
			endcase
		end
	end

	// latch the request address when a cycle starts
	always_ff @(posedge clk) begin
		if (state == fetch_pkg::bus_idle && fetch_req && !flush)
			adr_q <= fetch_adr;
	end

	// cyc and stb move together for the whole cycle
	assign wb_cyc = state != fetch_pkg::bus_idle;
	assign wb_stb = state != fetch_pkg::bus_idle;
	// read only
	assign wb_we = 1'b0;
	assign wb_adr = adr_q;

	// data is presented on the ack cycle and captured by the pc block
	assign window = wb_dat_i;
	// no pulse for a held cycle or one flushed on its ack
	assign window_valid = wb_ack && state == fetch_pkg::bus_read && !flush;

endmodule

`default_nettype wire

// ==== rtl/program_counter.sv ====
// program counter: fetch window register, slot selection, next-pc priority, group output
`default_nettype none

module program_counter (
	input  logic                    clk,
	input  logic                    rst,
	input  fetch_pkg::window_t      window,
	input  logic                    window_valid,
	input  fetch_pkg::slot_decode_t dec0,
	input  fetch_pkg::slot_decode_t dec1,
	input  logic                    freeze,
	input  logic                    branchmiss,
	input  fetch_pkg::addr_t        misspc,
	output logic                    fetch_req,
	output fetch_pkg::addr_t        fetch_adr,
	output logic                    flush,
	output fetch_pkg::addr_t        slot1_pc,
	output fetch_pkg::insn_t        slot1_bytes,
	output fetch_pkg::insn_t        slot0_bytes,
	output fetch_pkg::fetch_group_t group,
	output logic                    group_valid
);

	fetch_pkg::addr_t pc;
	fetch_pkg::window_t win_q;
	// a group is held for decode
	logic gv;
	// group taken by decode at this edge
	logic accept;
	logic valid1;
	fetch_pkg::addr_t next_pc;

	// ========================================
	// slot selection
	// ========================================
	assign slot0_bytes = win_q[23:0];
	assign slot1_pc = pc + fetch_pkg::addr_t'(dec0.len);

	// slot 1 starts right after slot 0
	always_comb begin
		case (dec0.len)
			2'd2: slot1_bytes = win_q[39:16];
			2'd3: slot1_bytes = win_q[47:24];
			default: slot1_bytes = win_q[31:8];
		endcase
	end

	// a taken slot 0 kills slot 1
	assign valid1 = !dec0.taken;
	assign accept = gv && !freeze;

	// taken slot 0, then taken slot 1, then sequential
	always_comb begin
		if (dec0.taken)
			next_pc = dec0.target;
		else if (dec1.taken)
			next_pc = dec1.target;
		else
			next_pc = slot1_pc + fetch_pkg::addr_t'(dec1.len);
	end

	// ========================================
	// pc and group state
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= fetch_pkg::RESET_VECTOR;
			gv <= 1'b0;
		end else if (branchmiss) begin
			// execute correction wins over everything
			pc <= misspc;
			gv <= 1'b0;
		end else if (accept) begin
			pc <= next_pc;
			gv <= 1'b0;
		end else if (window_valid) begin
			gv <= 1'b1;
		end
	end

	// window captured on the ack edge
	always_ff @(posedge clk) begin
		if (window_valid)
			win_q <= window;
	end

	// one fetch at a time, only when no group is held
	assign fetch_req = !gv;
	assign fetch_adr = pc;
	// abandon an in-flight read on a miss
	assign flush = branchmiss;

	// group fields only change with pc and win_q, so freeze holds them
	assign group.valid0 = gv;
	assign group.valid1 = gv && valid1;
	assign group.pc0 = pc;
	assign group.pc1 = slot1_pc;
	assign group.insn0 = slot0_bytes;
	assign group.insn1 = slot1_bytes;
	assign group_valid = gv;

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
// fetch front end top: Wishbone read master, two slot predecoders and program counter
`default_nettype none

module fetch_unit (
	input  logic                    clk,
	input  logic                    rst,
	// Wishbone classic master
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output fetch_pkg::addr_t        wb_adr,
	input  fetch_pkg::window_t      wb_dat_i,
	input  logic                    wb_ack,
	// decode side
	output fetch_pkg::fetch_group_t group,
	output logic                    group_valid,
	input  logic                    freeze,
	input  logic                    branchmiss,
	input  fetch_pkg::addr_t        misspc,
	input  fetch_pkg::addr_t        ra
);

	logic fetch_req;
	fetch_pkg::addr_t fetch_adr;
	logic flush;
	fetch_pkg::window_t window;
	logic window_valid;
	fetch_pkg::slot_decode_t dec0;
	fetch_pkg::slot_decode_t dec1;
	fetch_pkg::addr_t slot1_pc;
	fetch_pkg::insn_t slot0_bytes;
	fetch_pkg::insn_t slot1_bytes;

	fetch_bus_master u_bus (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_adr(fetch_adr),
		.flush(flush),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.window(window),
		.window_valid(window_valid)
	);

	// slot 0 sits at the current pc
	insn_predecode u_slot0 (
		.slot_pc(fetch_adr),
		.bytes(slot0_bytes),
		.ra(ra),
		.dec(dec0)
	);

	// slot 1 follows slot 0
	insn_predecode u_slot1 (
		.slot_pc(slot1_pc),
		.bytes(slot1_bytes),
		.ra(ra),
		.dec(dec1)
	);

	program_counter u_pc (
		.clk(clk),
		.rst(rst),
		.window(window),
		.window_valid(window_valid),
		.dec0(dec0),
		.dec1(dec1),
		.freeze(freeze),
		.branchmiss(branchmiss),
		.misspc(misspc),
		.fetch_req(fetch_req),
		.fetch_adr(fetch_adr),
		.flush(flush),
		.slot1_pc(slot1_pc),
		.slot1_bytes(slot1_bytes),
		.slot0_bytes(slot0_bytes),
		.group(group),
		.group_valid(group_valid)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_wb_memory.sv ====
// Wishbone classic slave model: 64 KiB byte image, 8-byte reads, random ack delay
`default_nettype none

module tb_wb_memory (
	input  logic               clk,
	input  logic               rst,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  fetch_pkg::addr_t   wb_adr,
	// extra wait cycles for the next read, 0 to 3
	input  logic [1:0]         ack_delay,
	output fetch_pkg::window_t wb_dat_o,
	output logic               wb_ack
);

	// byte image, loaded by the testbench
	logic [7:0] mem [0:65535];
	// a read is being counted down
	logic busy;
	logic [1:0] wait_cnt;

	// byte 0 in the low bits, address wraps at 64 KiB
	assign wb_dat_o = {mem[wb_adr + 16'd7], mem[wb_adr + 16'd6], mem[wb_adr + 16'd5],
		mem[wb_adr + 16'd4], mem[wb_adr + 16'd3], mem[wb_adr + 16'd2],
		mem[wb_adr + 16'd1], mem[wb_adr]};

	// ========================================
	// ack timing
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= 2'd0;
		end else if (wb_ack) begin
			// single-cycle ack, master drops cyc at this edge
			wb_ack <= 1'b0;
			busy <= 1'b0;
		end else if (wb_cyc && wb_stb && !wb_we && !busy) begin
			busy <= 1'b1;
			wait_cnt <= ack_delay;
		end else if (busy) begin
			if (wait_cnt == 2'd0)
				wb_ack <= 1'b1;
			else
				wait_cnt <= wait_cnt - 2'd1;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/fetch_unit_asserts.sv ====
// Wishbone classic and decode-side protocol assertions for the fetch front end
`default_nettype none

module fetch_unit_asserts (
	input logic                    clk,
	input logic                    rst,
	input logic                    wb_cyc,
	input logic                    wb_stb,
	input logic                    wb_we,
	input fetch_pkg::addr_t        wb_adr,
	input logic                    wb_ack,
	input fetch_pkg::fetch_group_t group,
	input logic                    group_valid,
	input logic                    freeze,
	input logic                    branchmiss
);

	// ========================================
	// memory side
	// ========================================
	cyc_stb_together: assert property (@(posedge clk) disable iff (rst) wb_cyc == wb_stb)
		else $error("wb_cyc and wb_stb differ");

	// read only master
	no_write: assert property (@(posedge clk) !wb_we)
		else $error("wb_we went high");

	// address and cyc hold until the ack cycle
	adr_held: assert property (@(posedge clk) disable iff (rst)
		(wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr)))
		else $error("wb_adr changed or cyc dropped before ack");

	// ========================================
	// reset and decode side
	// ========================================
	reset_quiet: assert property (@(posedge clk) rst |=> (!wb_cyc && !group_valid))
		else $error("bus cycle or group valid right after reset");

	group_frozen: assert property (@(posedge clk) disable iff (rst)
		(group_valid && freeze && !branchmiss) |=> (group_valid && $stable(group)))
		else $error("group changed while frozen");

	// held window means no new fetch
	no_fetch_frozen: assert property (@(posedge clk) disable iff (rst)
		(group_valid && freeze) |-> !wb_cyc)
		else $error("bus cycle started while a frozen group is held");

endmodule

bind fetch_unit fetch_unit_asserts u_asserts (
	.clk(clk),
	.rst(rst),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_we(wb_we),
	.wb_adr(wb_adr),
	.wb_ack(wb_ack),
	.group(group),
	.group_valid(group_valid),
	.freeze(freeze),
	.branchmiss(branchmiss)
);

`default_nettype wire

// ==== testbench/tb_fetch_unit.sv ====
// fetch front end testbench checking each fetch group under random freeze and branch misses
`default_nettype none

module tb_fetch_unit;

	localparam int GROUP_TOTAL = 400;
	localparam int GROUP_TIMEOUT = 200;
	localparam int MISS_TIMEOUT = 100;
	// address after the jsr at 0208
	localparam fetch_pkg::addr_t RET_ADDR = 16'h020B;

	logic clk;
	logic rst;
	logic freeze;
	logic branchmiss;
	fetch_pkg::addr_t misspc;
	fetch_pkg::addr_t ra;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_ack;
	fetch_pkg::addr_t wb_adr;
	fetch_pkg::window_t wb_dat;
	fetch_pkg::fetch_group_t group;
	logic group_valid;
	logic [1:0] ack_delay;
	logic [15:0] lfsr;
	// accepted groups so far
	int group_count;

	fetch_unit u_fetch_unit (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat),
		.wb_ack(wb_ack),
		.group(group),
		.group_valid(group_valid),
		.freeze(freeze),
		.branchmiss(branchmiss),
		.misspc(misspc),
		.ra(ra)
	);

	tb_wb_memory u_mem (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.ack_delay(ack_delay),
		.wb_dat_o(wb_dat),
		.wb_ack(wb_ack)
	);

	always #10 clk = ~clk;

	// ========================================
	// helpers
	// ========================================
	// galois step for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output logic [15:0] bits);
		bits = 16'h0000;
		for (int i = 0; i < n; i++) begin
			bits = {bits[14:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [7:0] mem_byte(input fetch_pkg::addr_t a);
		return u_mem.mem[a];
	endfunction

	function automatic fetch_pkg::insn_t insn_at(input fetch_pkg::addr_t a);
		return {mem_byte(a + 16'd2), mem_byte(a + 16'd1), mem_byte(a)};
	endfunction

	// write one instruction of n bytes into the image
	task automatic place(input fetch_pkg::addr_t at, input int n, input logic [7:0] b0,
		input logic [7:0] b1, input logic [7:0] b2);
		u_mem.mem[at] = b0;
		if (n > 1)
			u_mem.mem[at + 16'd1] = b1;
		if (n > 2)
			u_mem.mem[at + 16'd2] = b2;
	endtask

	// jumps, calls and returns predicted taken and branches only when backward
	task automatic predict(input fetch_pkg::addr_t at, output logic taken,
		output fetch_pkg::addr_t target);
		logic [7:0] op;
		logic [7:0] off;
		op = mem_byte(at);
		off = mem_byte(at + 16'd1);
		taken = 1'b1;
		target = {mem_byte(at + 16'd2), off};
		if (op == fetch_pkg::OP_RTS) begin
			target = ra;
		end else if (op[4:0] == 5'b10000) begin
			taken = off[7];
			target = at + 16'd2 + {{8{off[7]}}, off};
		end else if (op != fetch_pkg::OP_JMP && op != fetch_pkg::OP_JSR) begin
			taken = 1'b0;
		end
	endtask

	task automatic check_field(input string name, input logic [23:0] exp,
		input logic [23:0] act);
		assert (act == exp) else begin
			$display("Error: group %0d %s expected %h actual %h", group_count, name, exp, act);
			$display("Finished with errors");
			$fatal(1, "fetch group mismatch");
		end
	endtask

	task automatic load_image();
		for (int a = 0; a < 65536; a++)
			u_mem.mem[a[15:0]] = fetch_pkg::OP_BRK;
		// ldx #3, inx, lda abs, beq forward, jsr sub, nop, sta abs, jmp loop
		place(16'h0200, 2, 8'hA2, 8'h03, 8'h00);
		place(16'h0202, 1, 8'hE8, 8'h00, 8'h00);
		place(16'h0203, 3, 8'hAD, 8'h00, 8'h30);
		place(16'h0206, 2, 8'hF0, 8'h04, 8'h00);
		place(16'h0208, 3, 8'h20, 8'h20, 8'h02);
		place(16'h020B, 1, 8'hEA, 8'h00, 8'h00);
		place(16'h020C, 3, 8'h8D, 8'h00, 8'h31);
		place(16'h020F, 3, 8'h4C, 8'h30, 8'h02);
		// subroutine
		place(16'h0220, 1, 8'hE8, 8'h00, 8'h00);
		place(16'h0221, 2, 8'hA2, 8'h07, 8'h00);
		place(16'h0223, 1, 8'h60, 8'h00, 8'h00);
		// loop closed by a backward bne to 0230
		place(16'h0230, 1, 8'hE8, 8'h00, 8'h00);
		place(16'h0231, 1, 8'hCA, 8'h00, 8'h00);
		place(16'h0232, 1, 8'hA9, 8'h00, 8'h00);
		place(16'h0233, 2, 8'hD0, 8'hFB, 8'h00);
	endtask

	// ========================================
	// stimulus and checks
	// ========================================
	initial begin
		fetch_pkg::addr_t exp_pc;
		fetch_pkg::addr_t pc1;
		fetch_pkg::addr_t target0;
		fetch_pkg::addr_t target1;
		fetch_pkg::addr_t next_misspc;
		fetch_pkg::insn_len_t len0;
		fetch_pkg::insn_len_t len1;
		logic taken0;
		logic taken1;
		logic next_miss;
		logic miss_armed;
		logic miss_now;
		logic [15:0] bits;
		logic [15:0] freeze_bits;
		int idle;
		int miss_wait;
		int misses;
		clk = 1'b0;
		rst = 1'b1;
		freeze = 1'b0;
		branchmiss = 1'b0;
		misspc = fetch_pkg::RESET_VECTOR;
		ra = RET_ADDR;
		ack_delay = 2'd0;
		lfsr = 16'd5685;
		group_count = 0;
		load_image();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		exp_pc = fetch_pkg::RESET_VECTOR;
		idle = 0;
		miss_wait = 0;
		misses = 0;
		miss_armed = 1'b0;
		while (group_count < GROUP_TOTAL) begin
			@(negedge clk);
			next_miss = 1'b0;
			next_misspc = misspc;
			if (branchmiss) begin
				// miss beats a group accepted in the same cycle
				exp_pc = misspc;
			end else if (group_valid && !freeze) begin
				len0 = fetch_pkg::len_of(mem_byte(exp_pc));
				pc1 = exp_pc + fetch_pkg::addr_t'(len0);
				len1 = fetch_pkg::len_of(mem_byte(pc1));
				predict(exp_pc, taken0, target0);
				predict(pc1, taken1, target1);
				check_field("valid0", 24'd1, {23'd0, group.valid0});
				check_field("pc0", {8'h00, exp_pc}, {8'h00, group.pc0});
				check_field("insn0", insn_at(exp_pc), group.insn0);
				check_field("valid1", {23'd0, !taken0}, {23'd0, group.valid1});
				if (!taken0) begin
					check_field("pc1", {8'h00, pc1}, {8'h00, group.pc1});
					check_field("insn1", insn_at(pc1), group.insn1);
				end
				// taken slot 0, then taken slot 1, then sequential
				if (taken0)
					exp_pc = target0;
				else if (taken1)
					exp_pc = target1;
				else
					exp_pc = pc1 + fetch_pkg::addr_t'(len1);
				group_count++;
				idle = 0;
				if (group_count % 16 == 0)
					miss_armed = 1'b1;
			end
			idle++;
			if (idle > GROUP_TIMEOUT) begin
				$display("timeout: no fetch group accepted for %0d cycles", GROUP_TIMEOUT);
				$display("Finished with errors");
				$fatal(1, "fetch stalled");
			end
			// a miss lands on a read still in flight or on a frozen group held for decode
			if (miss_armed) begin
				miss_wait++;
				if (miss_wait > MISS_TIMEOUT) begin
					$display("timeout: no read or held group to hit with a branch miss");
					$display("Finished with errors");
					$fatal(1, "miss never applied");
				end
				if (misses[1])
					miss_now = group_valid && freeze;
				else
					miss_now = wb_cyc && !wb_ack;
				if (miss_now && !branchmiss) begin
					draw_bits(16, bits);
					next_miss = 1'b1;
					// odd misses go to a random address and even ones restart the program
					next_misspc = misses[0] ? bits : fetch_pkg::RESET_VECTOR;
					misses++;
					miss_armed = 1'b0;
					miss_wait = 0;
				end
			end
			draw_bits(2, bits);
			draw_bits(2, freeze_bits);
			@(posedge clk);
			ack_delay <= bits[1:0];
			// freeze about one cycle in four
			freeze <= freeze_bits[1:0] == 2'b00;
			branchmiss <= next_miss;
			misspc <= next_misspc;
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/fetch_pkg.sv
rtl/insn_predecode.sv
rtl/fetch_bus_master.sv
rtl/program_counter.sv
rtl/fetch_unit.sv
testbench/tb_wb_memory.sv
testbench/fetch_unit_asserts.sv
testbench/tb_fetch_unit.sv

// ==== Makefile ====
# Verilator build and run for the fetch front end testbench

VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_fetch_unit
FILELIST ?= all.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
